// File: Makefile
TOP := backprop_update_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module backprop_update -f backprop_update.f

# pass only when the run prints the pass line
sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f backprop_update.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

// File: backprop_update.f
logic/fxp_pkg.sv
logic/bp_ctrl_pkg.sv
logic/backprop_decode.sv
logic/sample_store.sv
logic/gradient_accum.sv
logic/weight_update_scale.sv
logic/backprop_update.sv
sim/backprop_update_tb.sv

// File: logic/backprop_decode.sv
`timescale 1ns/10ps

module backprop_decode
    import fxp_pkg::*;
    import bp_ctrl_pkg::*;
#(
    parameter int SIZE = 3
) (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   active_train_i,
    input  logic   read_update_data_i,
    input  layer_t current_input_layer_i,
    input  data_t  learning_rate_i,
    output logic   store_en_o,
    output logic   upd_valid_o,
    output row_t   upd_row_o,
    output data_t  upd_lr_o,
    output layer_t layer_o
);

    phase_t phase_d;
    phase_t phase_q;
    row_t   count_q;
    row_t   row_sel;
    row_t   row_next;
    layer_t layer_q;

    // phase follows the two levels
    // a read cycle never stores, even with training active
    always_comb begin
        if (read_update_data_i) begin
            phase_d = PH_UPDATE;
        end else if (active_train_i) begin
            phase_d = PH_STORE;
        end else begin
            phase_d = PH_IDLE;
        end
    end

    // store strobe in the same cycle, write happens downstream at the edge
    assign store_en_o = (phase_d == PH_STORE);

    // first cycle of a burst issues row 0
    assign row_sel = (phase_q == PH_UPDATE) ? count_q : '0;

    // next row, wraps mod SIZE
    assign row_next = (row_sel == row_t'(SIZE - 1)) ? '0 : row_sel + row_t'(1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase_q     <= PH_IDLE;
            count_q     <= '0;
            layer_q     <= '0;
            upd_valid_o <= 1'b0;
        end else begin
            phase_q     <= phase_d;
            upd_valid_o <= (phase_d == PH_UPDATE);
            // counter only advances while reading
            // restart after the level drops comes from phase_q
            if (phase_d == PH_UPDATE) begin
                count_q <= row_next;
            end
            // layer of the latest store, kept for the whole update burst
            if (store_en_o) begin
                layer_q <= current_input_layer_i;
            end
        end
    end

    // row index and rate travel together down the pipe
    always_ff @(posedge clk) begin
        if (phase_d == PH_UPDATE) begin
            upd_row_o <= row_sel;
            upd_lr_o  <= learning_rate_i;
        end
    end

    assign layer_o = layer_q;

endmodule

// File: logic/backprop_update.sv
`timescale 1ns/10ps

module backprop_update
    import fxp_pkg::*;
    import bp_ctrl_pkg::*;
#(
    parameter int SIZE = 3
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             active_train_i,
    input  logic             read_update_data_i,
    input  layer_t           current_input_layer_i,
    input  row_t             current_input_row_i,
    input  data_t            learning_rate_i,
    // lane c sits at index c
    input  data_t [SIZE-1:0] diff_start_i,
    input  data_t [SIZE-1:0] diff_act_i,
    input  data_t [SIZE-1:0] diff_cost_i,
    output logic             is_update_weight_o,
    output layer_t           update_weight_layer_o,
    output row_t             update_weight_row_o,
    output data_t [SIZE-1:0] update_weight_value_o
);

    // decode to store and accum
    logic                       store_en;
    logic                       upd_valid;
    row_t                       upd_row;
    data_t                      upd_lr;

    // stored batch, [sample][lane]
    data_t [SIZE-1:0][SIZE-1:0] delta;
    data_t [SIZE-1:0][SIZE-1:0] start;

    // accum to scale
    logic                       acc_valid;
    row_t                       acc_row;
    data_t                      acc_lr;
    data_t [SIZE-1:0]           acc_sum;

    // decode, one cycle
    backprop_decode #(
        .SIZE (SIZE)
    ) u_decode (
        .clk                   (clk),
        .reset_i               (reset_i),
        .active_train_i        (active_train_i),
        .read_update_data_i    (read_update_data_i),
        .current_input_layer_i (current_input_layer_i),
        .learning_rate_i       (learning_rate_i),
        .store_en_o            (store_en),
        .upd_valid_o           (upd_valid),
        .upd_row_o             (upd_row),
        .upd_lr_o              (upd_lr),
        // latched layer goes straight out with every row
        .layer_o               (update_weight_layer_o)
    );

    // batch memory, written from the raw inputs
    sample_store #(
        .SIZE (SIZE)
    ) u_store (
        .clk                 (clk),
        .reset_i             (reset_i),
        .store_en_i          (store_en),
        .current_input_row_i (current_input_row_i),
        .diff_start_i        (diff_start_i),
        .diff_act_i          (diff_act_i),
        .diff_cost_i         (diff_cost_i),
        .delta_o             (delta),
        .start_o             (start)
    );

    // execute, one cycle
    gradient_accum #(
        .SIZE (SIZE)
    ) u_accum (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (upd_valid),
        .row_i   (upd_row),
        .lr_i    (upd_lr),
        .delta_i (delta),
        .start_i (start),
        .valid_o (acc_valid),
        .row_o   (acc_row),
        .lr_o    (acc_lr),
        .sum_o   (acc_sum)
    );

    // result, one cycle
    weight_update_scale #(
        .SIZE (SIZE)
    ) u_scale (
        .clk                   (clk),
        .reset_i               (reset_i),
        .valid_i               (acc_valid),
        .row_i                 (acc_row),
        .lr_i                  (acc_lr),
        .sum_i                 (acc_sum),
        .is_update_weight_o    (is_update_weight_o),
        .update_weight_row_o   (update_weight_row_o),
        .update_weight_value_o (update_weight_value_o)
    );

endmodule

// File: logic/bp_ctrl_pkg.sv
// control types for the training sequencer
package bp_ctrl_pkg;

    // layer tag carried with every output row
    typedef logic [31:0] layer_t;

    // row index or sample index
    typedef logic [31:0] row_t;

    // phase of the training control
    // idle: nothing presented
    // store: sample rows being written
    // update: gradient rows being read out
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_STORE  = 2'd1,
        PH_UPDATE = 2'd2
    } phase_t;

endpackage

// File: logic/fxp_pkg.sv
// signed q8.8 arithmetic shared by every stage
package fxp_pkg;

    // fraction bits of the q8.8 format
    localparam int FRAC_BITS = 8;

    // one signed q8.8 value
    typedef logic signed [15:0] data_t;

    // full signed product, realigned to q8.8
    // upper bits dropped, no saturation
    function automatic data_t fxp_mult(
        input data_t a,
        input data_t b
    );
        logic signed [31:0] prod;
        logic signed [31:0] shifted;
        prod    = a * b;
        // arithmetic shift keeps the sign of the product
        shifted = prod >>> FRAC_BITS;
        return shifted[15:0];
    endfunction

    // plain 16 bit add, wraps on overflow
    function automatic data_t fxp_add(
        input data_t a,
        input data_t b
    );
        data_t sum;
        sum = a + b;
        return sum;
    endfunction

endpackage

// File: logic/gradient_accum.sv
`timescale 1ns/10ps

module gradient_accum
    import fxp_pkg::*;
    import bp_ctrl_pkg::*;
#(
    parameter int SIZE = 3
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        valid_i,
    input  row_t                        row_i,
    input  data_t                       lr_i,
    // indexed [sample][lane], straight from the store
    input  data_t [SIZE-1:0][SIZE-1:0]  delta_i,
    input  data_t [SIZE-1:0][SIZE-1:0]  start_i,
    output logic                        valid_o,
    output row_t                        row_o,
    output data_t                       lr_o,
    output data_t [SIZE-1:0]            sum_o
);

    // lane k of the error term, one entry per sample
    data_t [SIZE-1:0] delta_sel;
    data_t [SIZE-1:0] sum_d;

    // pick delta_i[k] out of every stored sample
    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            delta_sel[i] = '0;
            for (int k = 0; k < SIZE; k++) begin
                if (row_i == row_t'(k)) begin
                    delta_sel[i] = delta_i[i][k];
                end
            end
        end
    end

    // column sums of the outer product
    // chain runs sample 0 first, wrap order matters
    always_comb begin
        data_t acc;
        for (int c = 0; c < SIZE; c++) begin
            acc = '0;
            for (int i = 0; i < SIZE; i++) begin
                acc = fxp_add(acc, fxp_mult(delta_sel[i], start_i[i][c]));
            end
            sum_d[c] = acc;
        end
    end

    // valid bit is the only control here
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // sum registered with its row tag and rate
    always_ff @(posedge clk) begin
        if (valid_i) begin
            sum_o <= sum_d;
            row_o <= row_i;
            lr_o  <= lr_i;
        end
    end

endmodule

// File: logic/sample_store.sv
`timescale 1ns/10ps

module sample_store
    import fxp_pkg::*;
    import bp_ctrl_pkg::*;
#(
    parameter int SIZE = 3
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        store_en_i,
    input  row_t                        current_input_row_i,
    input  data_t [SIZE-1:0]            diff_start_i,
    input  data_t [SIZE-1:0]            diff_act_i,
    input  data_t [SIZE-1:0]            diff_cost_i,
    // indexed [sample][lane]
    output data_t [SIZE-1:0][SIZE-1:0]  delta_o,
    output data_t [SIZE-1:0][SIZE-1:0]  start_o
);

    data_t [SIZE-1:0] delta_in;
    logic             row_ok;

    // error term per lane: cost derivative times activation derivative
    always_comb begin
        for (int c = 0; c < SIZE; c++) begin
            delta_in[c] = fxp_mult(diff_cost_i[c], diff_act_i[c]);
        end
    end

    // rows past the batch depth are dropped
    assign row_ok = store_en_i && (current_input_row_i < row_t'(SIZE));

    // one sample per row
    // readers see the new row in the cycle after the write edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            delta_o <= '0;
            start_o <= '0;
        end else if (row_ok) begin
            for (int r = 0; r < SIZE; r++) begin
                if (current_input_row_i == row_t'(r)) begin
                    delta_o[r] <= delta_in;
                    // activation vector kept as given
                    start_o[r] <= diff_start_i;
                end
            end
        end
    end

endmodule

// File: logic/weight_update_scale.sv
`timescale 1ns/10ps

module weight_update_scale
    import fxp_pkg::*;
    import bp_ctrl_pkg::*;
#(
    parameter int SIZE = 3
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             valid_i,
    input  row_t             row_i,
    input  data_t            lr_i,
    input  data_t [SIZE-1:0] sum_i,
    output logic             is_update_weight_o,
    output row_t             update_weight_row_o,
    output data_t [SIZE-1:0] update_weight_value_o
);

    data_t [SIZE-1:0] scaled;

    // every lane times the rate sampled with this row
    always_comb begin
        for (int c = 0; c < SIZE; c++) begin
            scaled[c] = fxp_mult(sum_i[c], lr_i);
        end
    end

    // strobe is one cycle per row, never held
    always_ff @(posedge clk) begin
        if (reset_i) begin
            is_update_weight_o <= 1'b0;
        end else begin
            is_update_weight_o <= valid_i;
        end
    end

    // output payload
    always_ff @(posedge clk) begin
        if (valid_i) begin
            update_weight_row_o   <= row_i;
            update_weight_value_o <= scaled;
        end
    end

endmodule

// File: sim/backprop_update_tb.sv
`timescale 1ns/10ps

module backprop_update_tb;

    localparam int SIZE        = 3;
    localparam int RESET_LEN   = 5;
    // pipeline depth plus two quiet cycles
    localparam int DRAIN_LEN   = 5;
    localparam int LONG_BURST  = 2 * SIZE + 2;
    localparam int RAND_CYCLES = 200;
    // cycles per test, drain included
    localparam int TOTAL_CYCLES = (RESET_LEN + 3)
                                + 2 * (2 * SIZE + DRAIN_LEN)
                                + (LONG_BURST + DRAIN_LEN)
                                + (4 * SIZE + DRAIN_LEN)
                                + (RAND_CYCLES + DRAIN_LEN);
    localparam int CYCLE_LIMIT = 2 * TOTAL_CYCLES + 100;

    // one expected output row
    typedef struct packed {
        int                    due;
        int                    row;
        logic [SIZE-1:0][15:0] value;
    } expect_t;

    logic                  clk;
    logic                  reset_i;
    logic                  active_train_i;
    logic                  read_update_data_i;
    logic [31:0]           current_input_layer_i;
    logic [31:0]           current_input_row_i;
    logic [15:0]           learning_rate_i;
    logic [SIZE-1:0][15:0] diff_start_i;
    logic [SIZE-1:0][15:0] diff_act_i;
    logic [SIZE-1:0][15:0] diff_cost_i;
    logic                  is_update_weight_o;
    logic [31:0]           update_weight_layer_o;
    logic [31:0]           update_weight_row_o;
    logic [SIZE-1:0][15:0] update_weight_value_o;

    // model state, [sample][lane]
    logic [15:0] delta_m [SIZE][SIZE];
    logic [15:0] start_m [SIZE][SIZE];
    logic [31:0] layer_m;
    int          rd_count;
    expect_t     expect_q[$];
    int          cycles = 0;
    string       test_name;

    backprop_update #(
        .SIZE (SIZE)
    ) dut (
        .clk                   (clk),
        .reset_i               (reset_i),
        .active_train_i        (active_train_i),
        .read_update_data_i    (read_update_data_i),
        .current_input_layer_i (current_input_layer_i),
        .current_input_row_i   (current_input_row_i),
        .learning_rate_i       (learning_rate_i),
        .diff_start_i          (diff_start_i),
        .diff_act_i            (diff_act_i),
        .diff_cost_i           (diff_cost_i),
        .is_update_weight_o    (is_update_weight_o),
        .update_weight_layer_o (update_weight_layer_o),
        .update_weight_row_o   (update_weight_row_o),
        .update_weight_value_o (update_weight_value_o)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    // watchdog on the posedge count
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            abort_run();
        end
    end

    task automatic check_equal(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("Fail %s %s: expected %0d actual %0d", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    // q8.8 product, bits 23:8 of the full signed product
    function automatic logic [15:0] q_product(input logic [15:0] a, input logic [15:0] b);
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic signed [31:0] full;
        wa   = {{16{a[15]}}, a};
        wb   = {{16{b[15]}}, b};
        full = wa * wb;
        return full[23:8];
    endfunction

    // data within +-4.0
    function automatic logic [15:0] rand_data();
        return 16'($urandom_range(2048, 0)) - 16'd1024;
    endfunction

    // expected row k, from the model batch as it is now
    task automatic issue_row(input int k, input logic [15:0] lr);
        expect_t     e;
        logic [15:0] acc;
        e.due = cycles + 3;
        e.row = k;
        for (int c = 0; c < SIZE; c++) begin
            acc = '0;
            // sample 0 first, 16 bit wrap
            for (int i = 0; i < SIZE; i++) begin
                acc = acc + q_product(delta_m[i][k], start_m[i][c]);
            end
            e.value[c] = q_product(acc, lr);
        end
        expect_q.push_back(e);
    endtask

    task automatic check_outputs();
        expect_t e;
        if (is_update_weight_o) begin
            if (expect_q.size() == 0) begin
                $display("update strobe at cycle %0d with no row expected", cycles);
                abort_run();
            end else begin
                e = expect_q.pop_front();
                check_equal("latency", e.due, cycles);
                check_equal("row", e.row, int'(update_weight_row_o));
                check_equal("layer", int'(layer_m), int'(update_weight_layer_o));
                for (int c = 0; c < SIZE; c++) begin
                    check_equal($sformatf("lane %0d", c), int'($signed(e.value[c])),
                                int'($signed(update_weight_value_o[c])));
                end
            end
        end else if (expect_q.size() != 0 && expect_q[0].due <= cycles) begin
            $display("update row %0d did not appear at cycle %0d", expect_q[0].row, cycles);
            abort_run();
        end
    endtask

    task automatic advance();
        @(posedge clk);
        @(negedge clk);
        check_outputs();
    endtask

    // one clock of stimulus, model updated alongside
    task automatic cycle(input logic active, input logic read,
                         input logic [31:0] row, input logic [31:0] layer);
        active_train_i        = active;
        read_update_data_i    = read;
        current_input_row_i   = row;
        current_input_layer_i = layer;
        learning_rate_i       = 16'($urandom_range(256, 0));
        for (int c = 0; c < SIZE; c++) begin
            diff_start_i[c] = rand_data();
            diff_act_i[c]   = rand_data();
            diff_cost_i[c]  = rand_data();
        end
        if (read) begin
            issue_row(rd_count % SIZE, learning_rate_i);
            rd_count++;
        end else begin
            rd_count = 0;
        end
        // layer latches even for an out of range row
        if (active && !read) begin
            layer_m = layer;
            if (row < SIZE) begin
                for (int c = 0; c < SIZE; c++) begin
                    delta_m[row][c] = q_product(diff_cost_i[c], diff_act_i[c]);
                    start_m[row][c] = diff_start_i[c];
                end
            end
        end
        advance();
    endtask

    task automatic store_batch(input logic [31:0] layer);
        for (int r = 0; r < SIZE; r++) begin
            cycle(1'b1, 1'b0, r, layer);
        end
    endtask

    task automatic read_burst(input int n);
        repeat (n) cycle(1'b0, 1'b1, '0, '0);
    endtask

    // wait for every issued row, then a couple of quiet cycles
    task automatic drain();
        while (expect_q.size() != 0) begin
            cycle(1'b0, 1'b0, '0, '0);
        end
        repeat (2) cycle(1'b0, 1'b0, '0, '0);
    endtask

    task automatic run_reset();
        test_name = "reset";
        reset_i   = 1'b1;
        repeat (RESET_LEN) begin
            advance();
            check_equal("strobe in reset", 0, int'(is_update_weight_o));
        end
        reset_i = 1'b0;
        repeat (3) begin
            cycle(1'b0, 1'b0, '0, '0);
            check_equal("strobe after reset", 0, int'(is_update_weight_o));
        end
    endtask

    task automatic run_ignored_stores();
        test_name = "ignored stores";
        // training off
        repeat (SIZE) cycle(1'b0, 1'b0, $urandom_range(SIZE - 1, 0), $urandom());
        // training on during a read burst
        for (int r = 0; r < SIZE; r++) begin
            cycle(1'b1, 1'b1, r, $urandom());
        end
        // row past the batch depth
        repeat (SIZE) cycle(1'b1, 1'b0, $urandom_range(1000, SIZE), $urandom());
        read_burst(SIZE);
        drain();
    endtask

    task automatic run_random_mix();
        int   pick;
        logic reading;
        test_name = "random mix";
        reading   = 1'b0;
        repeat (RAND_CYCLES) begin
            pick = $urandom_range(9, 0);
            // a burst tends to go on once started
            reading = reading ? (pick < 7) : (pick < 3);
            if (reading) begin
                cycle(1'($urandom_range(1, 0)), 1'b1, '0, $urandom());
            end else if (pick >= 5) begin
                cycle(1'b1, 1'b0, $urandom_range(SIZE + 1, 0), $urandom_range(3, 0));
            end else begin
                cycle(1'b0, 1'b0, '0, '0);
            end
        end
        drain();
    endtask

    initial begin
        void'($urandom(88491));
        clk                   = 1'b0;
        reset_i               = 1'b1;
        active_train_i        = 1'b0;
        read_update_data_i    = 1'b0;
        current_input_layer_i = '0;
        current_input_row_i   = '0;
        learning_rate_i       = '0;
        diff_start_i          = '0;
        diff_act_i            = '0;
        diff_cost_i           = '0;
        layer_m               = '0;
        rd_count              = 0;
        for (int i = 0; i < SIZE; i++) begin
            for (int c = 0; c < SIZE; c++) begin
                delta_m[i][c] = '0;
                start_m[i][c] = '0;
            end
        end
        run_reset();
        test_name = "full batch";
        store_batch($urandom());
        read_burst(SIZE);
        drain();
        // rate is redrawn every cycle of the burst
        test_name = "rate per row";
        store_batch($urandom());
        read_burst(SIZE);
        drain();
        test_name = "long burst";
        read_burst(LONG_BURST);
        drain();
        run_ignored_stores();
        run_random_mix();
        if (expect_q.size() != 0) begin
            $display("%0d update rows never appeared", expect_q.size());
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule
